/* sim.f */
+incdir+include
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_pc_unit.sv
hdl/rv_core.sv
dv/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_core_tb -f sim.f -o rv_core_sim

./obj_dir/rv_core_sim 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
  exit 1
fi

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb
  import rv_core_pkg::*;
  import rv_isa_pkg::*;
();

  localparam int PROG_WORDS  = 64;
  localparam int HOLD_CYCLES = 4;
  localparam int NUM_TESTS   = 6;
  // per test the whole program array plus reset, halt hold and slack
  localparam int WATCHDOG_NS = NUM_TESTS * (PROG_WORDS + 3 + 8 + 2) * 40 + 2000;

  logic     clk = 1'b0;
  logic     rst;
  word_t    insn;
  word_t    pc;
  logic     halt;
  logic     illegal;
  logic     wb_valid;
  reg_idx_t wb_rd;
  word_t    wb_data;

  word_t prog [PROG_WORDS];
  word_t mreg [`RV_NUM_REGS];
  word_t mpc;
  logic  mhalt;
  word_t rng = 32'h316a_eb00;
  int    plen;
  int    errors;
  int    n_pass;
  int    n_fail;

  rv_core u_dut (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .pc       (pc),
    .halt     (halt),
    .illegal  (illegal),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  always #20 clk = ~clk;

  // instruction memory read in the same cycle
  assign insn = prog[pc[7:2]];

  function automatic word_t xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic word_t itype(logic [2:0] f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op_imm};
  endfunction

  function automatic word_t rtype(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
  endfunction

  function automatic word_t btype(logic [2:0] f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t utype(int rd, int imm);
    return {imm[19:0], rd[4:0], op_lui};
  endfunction

  function automatic word_t ecall_word();
    return {25'b0, op_system};
  endfunction

  // reference semantics of the base integer ops
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
      F3_SLTU:    return {31'b0, a < b};
      F3_XOR:     return a ^ b;
      F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  function automatic logic taken_ref(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return !($signed(a) < $signed(b));
      F3_BLTU: return a < b;
      default: return !(a < b);
    endcase
  endfunction

  task automatic check(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // compare one cycle against the model and retire it there
  task automatic check_cycle();
    word_t w;
    word_t res;
    word_t nxt;
    logic  we;
    logic  ill;
    logic  stop;
    w    = prog[mpc[7:2]];
    res  = '0;
    nxt  = mpc + 4;
    we   = 1'b0;
    ill  = 1'b0;
    stop = 1'b0;
    if (!mhalt) begin
      case (w[6:0])
        op_lui: begin
          we  = 1'b1;
          res = {w[31:12], 12'b0};
        end
        op_imm: begin
          we  = 1'b1;
          res = alu_ref(w[14:12], w[30] && w[14:12] == F3_SRL_SRA, mreg[w[19:15]],
                        {{20{w[31]}}, w[31:20]});
        end
        op_reg: begin
          we  = 1'b1;
          res = alu_ref(w[14:12], w[30], mreg[w[19:15]], mreg[w[24:20]]);
        end
        op_branch: begin
          if (taken_ref(w[14:12], mreg[w[19:15]], mreg[w[24:20]])) begin
            nxt = mpc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        op_system: stop = 1'b1;
        default:   ill = 1'b1;
      endcase
    end
    check("pc", mpc, pc);
    check("halt", word_t'(mhalt), word_t'(halt));
    check("illegal", word_t'(ill), word_t'(illegal));
    check("wb_valid", word_t'(we), word_t'(wb_valid));
    if (we) begin
      check("wb_rd", word_t'(w[11:7]), word_t'(wb_rd));
      check("wb_data", res, wb_data);
    end
    if (we && w[11:7] != 5'd0) begin
      mreg[w[11:7]] = res;
    end
    if (stop) begin
      mhalt = 1'b1;
    end else if (!mhalt) begin
      mpc = nxt;
    end
  endtask

  // nop fill with the word address as immediate
  task automatic clear_program();
    plen = 0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = itype(F3_ADD_SUB, 0, 0, i);
    end
  endtask

  task automatic emit(word_t w);
    prog[plen] = w;
    plen++;
  endtask

  task automatic run_program(string name, int hold);
    int held;
    int errs_before;
    held        = 0;
    errs_before = errors;
    emit(ecall_word());
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      mreg[i] = '0;
    end
    mpc   = `RV_RESET_PC;
    mhalt = 1'b0;
    rst   = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    while (held < hold) begin
      // sample just before the next edge
      #37;
      if (mhalt) begin
        held++;
      end
      check_cycle();
      @(posedge clk);
      #1;
      // a halted core must ignore whatever now sits at the frozen pc
      if (mhalt) begin
        prog[mpc[7:2]] = itype(F3_ADD_SUB, 1, 1, 1);
      end
    end
    if (errors == errs_before) begin
      n_pass++;
      $display("test %s passed", name);
    end else begin
      n_fail++;
      $display("test %s failed with %0d mismatches", name, errors - errs_before);
    end
  endtask

  task automatic imm_ops_test();
    clear_program();
    emit(utype(1, xorshift()));
    emit(itype(F3_ADD_SUB, 2, 1, xorshift()));
    emit(itype(F3_SLT, 3, 1, xorshift()));
    emit(itype(F3_SLTU, 4, 1, xorshift()));
    emit(itype(F3_XOR, 5, 1, xorshift()));
    emit(itype(F3_OR, 6, 1, xorshift()));
    emit(itype(F3_AND, 7, 1, xorshift()));
    emit(itype(F3_SLL, 8, 1, xorshift() & 31));
    emit(itype(F3_SRL_SRA, 9, 1, xorshift() & 31));
    emit(itype(F3_SRL_SRA, 10, 1, 32'h400 | (xorshift() & 31)));
    run_program("imm_ops", HOLD_CYCLES);
  endtask

  task automatic reg_ops_test();
    logic [2:0] f3s [10] = '{F3_ADD_SUB, F3_ADD_SUB, F3_SLL, F3_SLT, F3_SLTU,
                             F3_XOR, F3_SRL_SRA, F3_SRL_SRA, F3_OR, F3_AND};
    clear_program();
    // x1 negative and x2 positive
    emit(utype(1, xorshift() | 32'h8_0000));
    emit(itype(F3_ADD_SUB, 1, 1, xorshift() & 32'h7ff));
    emit(utype(2, xorshift() & 32'h7_ffff));
    emit(itype(F3_ADD_SUB, 2, 2, xorshift() & 32'h7ff));
    for (int i = 0; i < 10; i++) begin
      emit(rtype((i == 1 || i == 7) ? F7_ALT : F7_BASE, f3s[i], 3 + i, 1, 2));
    end
    emit(rtype(F7_BASE, F3_SLT, 13, 2, 1));
    emit(rtype(F7_BASE, F3_SLTU, 14, 2, 1));
    run_program("reg_ops", HOLD_CYCLES);
  endtask

  task automatic x0_write_test();
    clear_program();
    emit(utype(1, xorshift()));
    emit(itype(F3_ADD_SUB, 0, 1, xorshift()));
    emit(utype(0, xorshift()));
    emit(rtype(F7_BASE, F3_ADD_SUB, 3, 0, 0));
    emit(rtype(F7_BASE, F3_OR, 4, 0, 1));
    run_program("x0_write", HOLD_CYCLES);
  endtask

  task automatic branch_test();
    logic [2:0] f3s [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    // register pairs with x1 = -5 and x2 = 7
    int t1 [6] = '{1, 1, 1, 2, 2, 1};
    int t2 [6] = '{1, 2, 2, 1, 1, 2};
    int n1 [6] = '{1, 1, 2, 1, 1, 2};
    int n2 [6] = '{2, 1, 1, 2, 2, 1};
    clear_program();
    emit(itype(F3_ADD_SUB, 1, 0, -5));
    emit(itype(F3_ADD_SUB, 2, 0, 7));
    for (int i = 0; i < 6; i++) begin
      emit(btype(f3s[i], t1[i], t2[i], 8));
      emit(itype(F3_ADD_SUB, 3, 3, 1));
      emit(btype(f3s[i], n1[i], n2[i], 8));
      emit(itype(F3_ADD_SUB, 3, 3, 1));
    end
    // countdown loop closed by a backward bne
    emit(itype(F3_ADD_SUB, 4, 0, 3));
    emit(itype(F3_ADD_SUB, 4, 4, -1));
    emit(btype(F3_BNE, 4, 0, -4));
    run_program("branches", HOLD_CYCLES);
  endtask

  task automatic ecall_halt_test();
    clear_program();
    emit(itype(F3_ADD_SUB, 5, 0, xorshift()));
    emit(ecall_word());
    emit(itype(F3_ADD_SUB, 6, 0, 1));
    run_program("ecall_halt", 8);
  endtask

  task automatic illegal_store_test();
    clear_program();
    emit(itype(F3_ADD_SUB, 6, 0, 5));
    // sw x6, 0(x0)
    emit({7'b0, 5'd6, 5'd0, 3'b010, 5'd0, 7'b0100011});
    emit(itype(F3_ADD_SUB, 7, 6, 1));
    run_program("illegal_store", HOLD_CYCLES);
  endtask

  initial begin
    rst    = 1'b1;
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    clear_program();
    @(posedge clk);
    #1;
    imm_ops_test();
    reg_ops_test();
    x0_write_test();
    branch_test();
    ecall_halt_test();
    illegal_store_test();
    $display("tests passed %0d, failed %0d, mismatches %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    insn,
  output word_t    pc,
  output logic     halt,
  output logic     illegal,
  output logic     wb_valid,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      imm;
  word_t      branch_imm;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      alu_b;
  word_t      alu_result;
  alu_op_e    alu_op;
  logic       use_imm;
  logic       rf_we;
  logic       is_branch;
  logic       ecall;
  logic [2:0] funct3;

  rv_decoder u_decoder (
    .insn       (insn),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .branch_imm (branch_imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .rf_we      (rf_we),
    .is_branch  (is_branch),
    .ecall      (ecall),
    .illegal    (illegal),
    .funct3     (funct3)
  );

  // a halted core retires nothing
  assign wb_valid = rf_we && !halt;
  assign wb_rd    = rd;
  assign wb_data  = alu_result;

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .we       (wb_valid),
    .rd_data  (alu_result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .a      (rs1_data),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .is_branch  (is_branch),
    .ecall      (ecall),
    .funct3     (funct3),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .branch_imm (branch_imm),
    .pc         (pc),
    .halt       (halt)
  );

endmodule

/* hdl/rv_pc_unit.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_pc_unit
  import rv_core_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       is_branch,
  input  logic       ecall,
  input  logic [2:0] funct3,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  input  word_t      branch_imm,
  output word_t      pc,
  output logic       halt
);

  logic  taken;
  word_t pc_next;

  // branch condition
  always_comb begin
    case (funct3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
      F3_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      F3_BLTU: taken = rs1_data < rs2_data;
      F3_BGEU: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign pc_next = (is_branch && taken) ? pc + branch_imm : pc + word_t'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      if (ecall) begin
        // pc parks on the ecall
        halt <= 1'b1;
      end else begin
        pc <= pc_next;
      end
    end
  end

  // B offsets are only 2-byte aligned, so a bad target shows up here
  pc_aligned_a: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc unit: misaligned pc %h", pc);

endmodule

/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_alu
  import rv_core_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result
);

  localparam int SHAMT_W = $clog2(`RV_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  // shift amount is the low bits of b only
  assign shamt       = b[SHAMT_W-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = word_t'(lt_signed);
      alu_sltu:   result = word_t'(lt_unsigned);
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      // lui immediate goes straight through
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     we,
  input  word_t    rd_data,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [`RV_NUM_REGS];

  // asynchronous reads, x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // x0 drops the write
      regs[rd] <= rd_data;
    end
  end

endmodule

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decoder
  import rv_core_pkg::*;
  import rv_isa_pkg::*;
(
  input  word_t      insn,
  output reg_idx_t   rs1,
  output reg_idx_t   rs2,
  output reg_idx_t   rd,
  output word_t      imm,
  output word_t      branch_imm,
  output alu_op_e    alu_op,
  output logic       use_imm,
  output logic       rf_we,
  output logic       is_branch,
  output logic       ecall,
  output logic       illegal,
  output logic [2:0] funct3
);

  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;

  // alt selects sub / sra
  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: return alt ? alu_sub : alu_add;
      F3_SLL:     return alu_sll;
      F3_SLT:     return alu_slt;
      F3_SLTU:    return alu_sltu;
      F3_XOR:     return alu_xor;
      F3_SRL_SRA: return alt ? alu_sra : alu_srl;
      F3_OR:      return alu_or;
      default:    return alu_and;
    endcase
  endfunction

  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign branch_imm = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25],
                       insn[11:8], 1'b0};

  always_comb begin
    alu_op    = alu_add;
    imm       = imm_i;
    use_imm   = 1'b0;
    rf_we     = 1'b0;
    is_branch = 1'b0;
    ecall     = 1'b0;
    illegal   = 1'b0;
    case (opcode_e'(insn[6:0]))
      op_lui: begin
        alu_op  = alu_pass_b;
        imm     = imm_u;
        use_imm = 1'b1;
        rf_we   = 1'b1;
      end
      op_imm: begin
        use_imm = 1'b1;
        // addi has no sub form, only the shift field carries funct7
        alu_op  = f3_to_alu(funct3, funct7 == F7_ALT && funct3 == F3_SRL_SRA);
        if (funct3 == F3_SLL) begin
          illegal = (funct7 != F7_BASE);
        end else if (funct3 == F3_SRL_SRA) begin
          illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
        end
        rf_we = !illegal;
      end
      op_reg: begin
        alu_op  = f3_to_alu(funct3, funct7 == F7_ALT);
        illegal = !((funct7 == F7_BASE) ||
                    (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)));
        rf_we   = !illegal;
      end
      op_branch: begin
        is_branch = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        illegal   = !is_branch;
      end
      op_system: begin
        // only the all-zero ecall encoding
        ecall   = (insn[31:7] == '0);
        illegal = !ecall;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // an illegal encoding must never reach the register file
  always_comb begin
    assert (!(rf_we && illegal)) else $error("decoder: write enable on illegal insn");
  end

endmodule

/* hdl/rv_core_pkg.sv */
`include "rv_params.svh"

package rv_core_pkg;

  // one machine word: data, immediates and pc
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  // operations the alu knows
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

endpackage

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_branch = 7'b1100011,
    op_system = 7'b1110011
  } opcode_e;

  // alu minor codes, shared by op_imm and op_reg
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct7 picks add/sub and srl/sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* include/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// machine word, also the address width
`define RV_XLEN 32

// architectural integer registers x0..x31
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
